// File: hdl/cal_pkg.sv
// calculator package with main states, cursor positions, opcodes and operand types
package cal_pkg;

    localparam int digit_width    = 4;
    localparam int operand_digits = 3;
    localparam int result_digits  = 6;
    // holds +/-998001
    localparam int result_width   = 21;

    localparam int button_width = 5;
    localparam int switch_width = 3;

    // lower index wins on simultaneous presses
    localparam int btn_left  = 0;
    localparam int btn_right = 1;
    localparam int btn_up    = 2;
    localparam int btn_down  = 3;
    localparam int btn_mid   = 4;

    typedef logic [digit_width-1:0] bcd_t;

    typedef struct packed {
        logic                         sign;
        bcd_t [operand_digits-1:0]    digits;
    } operand_t;

    typedef enum logic [2:0] {
        st_idle, st_input_a, st_input_b, st_exe, st_convert, st_display
    } cal_state_e;

    typedef enum logic [2:0] {
        cur_idle, cur_digit0, cur_digit1, cur_digit2, cur_sign
    } cursor_e;

    typedef enum logic [1:0] {
        op_add, op_sub, op_mul, op_none
    } op_e;

endpackage

// File: hdl/disp_pkg.sv
// display package with glyph codes, segment patterns and result pages
package disp_pkg;

    localparam int scan_positions = 4;

    // codes past the decimal digits
    localparam logic [3:0] glyph_blank = 4'd10;
    localparam logic [3:0] glyph_minus = 4'd11;

    // active low, segments a to g then dp
    typedef logic [7:0] seg_t;
    // active low digit enables, bit 0 is the rightmost digit
    typedef logic [3:0] ctrl_t;

    typedef enum logic {
        page_low, page_high
    } page_e;

    localparam seg_t seg_patterns [12] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0001_1001,
        // blank
        8'b1111_1111,
        // minus
        8'b1111_1101
    };

endpackage

// File: hdl/bcd_result_if.sv
// decimal result bus from the binary to BCD converter to the display
`timescale 1ns/1ps

interface bcd_result_if;

    cal_pkg::bcd_t [cal_pkg::result_digits-1:0] digits;
    logic                                        sign;
    logic                                        invalid;
    // one cycle, digits hold until the next conversion
    logic                                        conv_done;

    modport source (
        output digits, sign, invalid, conv_done
    );

    modport sink (
        input digits, sign, invalid, conv_done
    );

endinterface

// File: hdl/cal_control.sv
// main calculator FSM sequencing entry, execute, conversion and display
`timescale 1ns/1ps

module cal_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                mid,
    input  logic                conv_done,
    input  logic                last_page,
    output cal_pkg::cal_state_e state,
    output logic                exe_done
);

    cal_pkg::cal_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            cal_pkg::st_idle: begin
                next_state = cal_pkg::st_input_a;
            end
            cal_pkg::st_input_a: begin
                if (mid) begin
                    next_state = cal_pkg::st_input_b;
                end
            end
            cal_pkg::st_input_b: begin
                if (mid) begin
                    next_state = cal_pkg::st_exe;
                end
            end
            // integer ops finish in a single cycle
            cal_pkg::st_exe: begin
                next_state = cal_pkg::st_convert;
            end
            cal_pkg::st_convert: begin
                if (conv_done) begin
                    next_state = cal_pkg::st_display;
                end
            end
            cal_pkg::st_display: begin
                if (mid && last_page) begin
                    next_state = cal_pkg::st_input_a;
                end
            end
            default: begin
                next_state = cal_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cal_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    assign exe_done = (state == cal_pkg::st_display);

endmodule

// File: hdl/digit_entry.sv
// operand entry with button priority, cursor FSM, digit registers and operand capture
`timescale 1ns/1ps

module digit_entry (
    input  logic                             clk,
    input  logic                             reset,
    input  cal_pkg::cal_state_e              state,
    input  logic [cal_pkg::button_width-1:0] button,
    output logic                             mid,
    output cal_pkg::operand_t                live_digits,
    output cal_pkg::operand_t                operand_a,
    output cal_pkg::operand_t                operand_b
);

    logic [cal_pkg::button_width-1:0] btn_q;
    logic                             left;
    logic                             right;
    logic                             up;
    logic                             down;
    logic                             entry;
    cal_pkg::cursor_e                 cursor;
    cal_pkg::cursor_e                 cursor_next;

    function automatic cal_pkg::bcd_t step_digit(cal_pkg::bcd_t d, logic inc);
        if (inc) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    // keep only the lowest pressed button
    assign btn_q = button & (~button + 1'b1);

    assign left  = btn_q[cal_pkg::btn_left];
    assign right = btn_q[cal_pkg::btn_right];
    assign up    = btn_q[cal_pkg::btn_up];
    assign down  = btn_q[cal_pkg::btn_down];
    assign mid   = btn_q[cal_pkg::btn_mid];

    assign entry = (state == cal_pkg::st_input_a) || (state == cal_pkg::st_input_b);

    always_comb begin
        cursor_next = cursor;
        if (!entry) begin
            cursor_next = cal_pkg::cur_idle;
        end else if (cursor == cal_pkg::cur_idle || mid) begin
            cursor_next = cal_pkg::cur_digit0;
        end else if (left) begin
            case (cursor)
                cal_pkg::cur_digit0: cursor_next = cal_pkg::cur_digit1;
                cal_pkg::cur_digit1: cursor_next = cal_pkg::cur_digit2;
                cal_pkg::cur_digit2: cursor_next = cal_pkg::cur_sign;
                default:             cursor_next = cursor;
            endcase
        end else if (right) begin
            case (cursor)
                cal_pkg::cur_sign:   cursor_next = cal_pkg::cur_digit2;
                cal_pkg::cur_digit2: cursor_next = cal_pkg::cur_digit1;
                cal_pkg::cur_digit1: cursor_next = cal_pkg::cur_digit0;
                default:             cursor_next = cursor;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cursor <= cal_pkg::cur_idle;
        end else begin
            cursor <= cursor_next;
        end
    end

    // live digits, cleared once the operand is taken
    always_ff @(posedge clk) begin
        if (reset || (entry && mid)) begin
            live_digits <= '0;
        end else if (entry && (up || down)) begin
            case (cursor)
                cal_pkg::cur_digit0: live_digits.digits[0] <= step_digit(live_digits.digits[0], up);
                cal_pkg::cur_digit1: live_digits.digits[1] <= step_digit(live_digits.digits[1], up);
                cal_pkg::cur_digit2: live_digits.digits[2] <= step_digit(live_digits.digits[2], up);
                cal_pkg::cur_sign:   live_digits.sign <= ~live_digits.sign;
                default:             live_digits <= live_digits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mid && state == cal_pkg::st_input_a) begin
            operand_a <= live_digits;
        end
        if (mid && state == cal_pkg::st_input_b) begin
            operand_b <= live_digits;
        end
    end

endmodule

// File: hdl/int_alu.sv
// integer alu with opcode decode, BCD to binary operands and registered add, sub or mul
`timescale 1ns/1ps

module int_alu (
    input  logic                                   clk,
    input  logic                                   reset,
    input  cal_pkg::cal_state_e                    state,
    input  logic [cal_pkg::switch_width-1:0]       switches,
    input  cal_pkg::operand_t                      operand_a,
    input  cal_pkg::operand_t                      operand_b,
    output logic signed [cal_pkg::result_width-1:0] result,
    output logic                                   invalid
);

    cal_pkg::op_e                            op;
    logic signed [cal_pkg::result_width-1:0] a_bin;
    logic signed [cal_pkg::result_width-1:0] b_bin;

    function automatic logic signed [cal_pkg::result_width-1:0] to_bin(cal_pkg::operand_t o);
        logic signed [cal_pkg::result_width-1:0] mag;
        mag = o.digits[2] * 100 + o.digits[1] * 10 + o.digits[0];
        return o.sign ? -mag : mag;
    endfunction

    // lowest set switch picks the op
    always_comb begin
        if (switches[0]) begin
            op = cal_pkg::op_add;
        end else if (switches[1]) begin
            op = cal_pkg::op_sub;
        end else if (switches[2]) begin
            op = cal_pkg::op_mul;
        end else begin
            op = cal_pkg::op_none;
        end
    end

    assign a_bin = to_bin(operand_a);
    assign b_bin = to_bin(operand_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            invalid <= 1'b0;
        end else if (state == cal_pkg::st_exe) begin
            invalid <= (op == cal_pkg::op_none);
        end
    end

    always_ff @(posedge clk) begin
        if (state == cal_pkg::st_exe) begin
            case (op)
                cal_pkg::op_add: result <= a_bin + b_bin;
                cal_pkg::op_sub: result <= a_bin - b_bin;
                cal_pkg::op_mul: result <= a_bin * b_bin;
                default:         result <= '0;
            endcase
        end
    end

endmodule

// File: hdl/bin2bcd.sv
// serial double dabble turning the result magnitude into six decimal digits
`timescale 1ns/1ps

module bin2bcd (
    input  logic                                   clk,
    input  logic                                   reset,
    input  cal_pkg::cal_state_e                    state,
    input  logic signed [cal_pkg::result_width-1:0] result,
    input  logic                                   invalid,
    bcd_result_if.source                           res
);

    localparam int mag_width = cal_pkg::result_width - 1;
    localparam int dw        = cal_pkg::digit_width;
    localparam int bcd_width = cal_pkg::result_digits * dw;

    logic [$clog2(mag_width)-1:0]    cnt;
    logic                            convert;
    logic                            first;
    logic [cal_pkg::result_width-1:0] abs_val;
    logic [mag_width-1:0]            bin_src;
    logic [mag_width-1:0]            bin_q;
    logic [bcd_width-1:0]            bcd_src;
    logic [bcd_width-1:0]            bcd_adj;
    logic [bcd_width-1:0]            bcd_q;
    logic                            sign_q;
    logic                            invalid_q;

    assign convert = (state == cal_pkg::st_convert);
    assign first   = convert && (cnt == '0);

    // first convert cycle shifts straight from the alu result
    assign abs_val = result[cal_pkg::result_width-1] ? -result : result;
    assign bin_src = first ? abs_val[mag_width-1:0] : bin_q;
    assign bcd_src = first ? '0 : bcd_q;

    always_comb begin
        for (int i = 0; i < cal_pkg::result_digits; i++) begin
            bcd_adj[i*dw +: dw] = (bcd_src[i*dw +: dw] >= 4'd5) ? bcd_src[i*dw +: dw] + 4'd3
                                                                : bcd_src[i*dw +: dw];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !convert) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (convert) begin
            {bcd_q, bin_q} <= {bcd_adj, bin_src} << 1;
        end
        if (first) begin
            sign_q    <= result[cal_pkg::result_width-1];
            invalid_q <= invalid;
        end
    end

    assign res.digits    = bcd_q;
    assign res.sign      = sign_q;
    assign res.invalid   = invalid_q;
    assign res.conv_done = convert && (cnt == mag_width - 1);

endmodule

// File: hdl/seg_display.sv
// seven segment scan with entry view, result pages and segment decode
`timescale 1ns/1ps

module seg_display #(
    parameter int scan_div_width = 10
) (
    input  logic                clk,
    input  logic                reset,
    input  cal_pkg::cal_state_e state,
    input  logic                mid,
    input  cal_pkg::operand_t   live_digits,
    bcd_result_if.sink          res,
    output logic                last_page,
    output disp_pkg::ctrl_t     digit_ctrl,
    output disp_pkg::seg_t      digit_seg,
    output logic [1:0]          display_stage
);

    localparam int pos_width = $clog2(disp_pkg::scan_positions);

    logic [scan_div_width-1:0] div_cnt;
    logic                      scan_tick;
    logic [pos_width-1:0]      pos;
    logic                      sign_pos;
    disp_pkg::page_e           page;
    logic                      entry;
    logic                      showing;
    logic                      active;
    logic [2:0]                res_idx;
    logic [3:0]                glyph;

    function automatic logic [3:0] sign_glyph(logic neg);
        return neg ? disp_pkg::glyph_minus : disp_pkg::glyph_blank;
    endfunction

    assign scan_tick = &div_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            pos     <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (scan_tick) begin
                pos <= pos + 1'b1;
            end
        end
    end

    assign entry    = (state == cal_pkg::st_input_a) || (state == cal_pkg::st_input_b);
    assign showing  = (state == cal_pkg::st_display);
    assign sign_pos = (pos == pos_width'(disp_pkg::scan_positions - 1));

    // an invalid result has a single page
    assign last_page = (page == disp_pkg::page_high) || res.invalid;

    always_ff @(posedge clk) begin
        if (reset || res.conv_done) begin
            page <= disp_pkg::page_low;
        end else if (showing && mid && !last_page) begin
            page <= disp_pkg::page_high;
        end
    end

    assign display_stage = showing ? {1'b0, page} + 2'd1 : 2'd0;

    // high page shows digits 5 to 3
    assign res_idx = (page == disp_pkg::page_high) ? 3'(pos) + 3'd3 : 3'(pos);

    always_comb begin
        glyph = disp_pkg::glyph_blank;
        if (entry) begin
            if (sign_pos) begin
                glyph = sign_glyph(live_digits.sign);
            end else begin
                glyph = live_digits.digits[pos];
            end
        end else if (showing) begin
            if (sign_pos) begin
                glyph = sign_glyph(res.sign);
            end else begin
                glyph = res.digits[res_idx];
            end
        end
    end

    assign active     = entry || (showing && !res.invalid);
    assign digit_ctrl = active ? ~(disp_pkg::ctrl_t'(1) << pos) : '1;
    assign digit_seg  = disp_pkg::seg_patterns[glyph];

endmodule

// File: hdl/cal_top.sv
// calculator top level connecting entry, alu, converter and seven segment display
`timescale 1ns/1ps

module cal_top #(
    parameter int scan_div_width = 10
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [cal_pkg::button_width-1:0] board_cal_button,
    input  logic [cal_pkg::switch_width-1:0] board_cal_switchs,
    output disp_pkg::ctrl_t                  cal_board_digit_ctrl,
    output disp_pkg::seg_t                   cal_board_digit_seg,
    output logic                             cal_board_exe_done,
    output logic [1:0]                       cal_board_display_stage
);

    cal_pkg::cal_state_e                     state;
    logic                                    mid;
    logic                                    last_page;
    cal_pkg::operand_t                       live_digits;
    cal_pkg::operand_t                       operand_a;
    cal_pkg::operand_t                       operand_b;
    logic signed [cal_pkg::result_width-1:0] result;
    logic                                    invalid;

    bcd_result_if res_bus ();

    cal_control u_cal_control (
        .clk       (clk),
        .reset     (reset),
        .mid       (mid),
        .conv_done (res_bus.conv_done),
        .last_page (last_page),
        .state     (state),
        .exe_done  (cal_board_exe_done)
    );

    digit_entry u_digit_entry (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .button      (board_cal_button),
        .mid         (mid),
        .live_digits (live_digits),
        .operand_a   (operand_a),
        .operand_b   (operand_b)
    );

    int_alu u_int_alu (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .switches  (board_cal_switchs),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (result),
        .invalid   (invalid)
    );

    bin2bcd u_bin2bcd (
        .clk     (clk),
        .reset   (reset),
        .state   (state),
        .result  (result),
        .invalid (invalid),
        .res     (res_bus.source)
    );

    seg_display #(
        .scan_div_width (scan_div_width)
    ) u_seg_display (
        .clk           (clk),
        .reset         (reset),
        .state         (state),
        .mid           (mid),
        .live_digits   (live_digits),
        .res           (res_bus.sink),
        .last_page     (last_page),
        .digit_ctrl    (cal_board_digit_ctrl),
        .digit_seg     (cal_board_digit_seg),
        .display_stage (cal_board_display_stage)
    );

endmodule

// File: verif/tb_cal_top.sv
// calculator testbench entering operands by button pulses and reading results off the display
`timescale 1ns/1ps

module tb_cal_top;

    localparam int num_rows  = 13;
    localparam int num_fixed = 9;
    localparam int rw        = cal_pkg::result_width;

    logic                             clk;
    logic                             reset;
    logic [cal_pkg::button_width-1:0] board_cal_button;
    logic [cal_pkg::switch_width-1:0] board_cal_switchs;
    disp_pkg::ctrl_t                  cal_board_digit_ctrl;
    disp_pkg::seg_t                   cal_board_digit_seg;
    logic                             cal_board_exe_done;
    logic [1:0]                       cal_board_display_stage;

    string                            t_name [num_rows];
    int                               t_a [num_rows];
    logic                             t_a_neg [num_rows];
    int                               t_b [num_rows];
    logic                             t_b_neg [num_rows];
    logic [cal_pkg::switch_width-1:0] t_sw [num_rows];
    logic signed [rw-1:0]             t_exp [num_rows];
    logic                             t_inv [num_rows];

    int          errors;
    int          tests;
    int          failed_tests;
    int unsigned seed;

    cal_top #(
        .scan_div_width (2)
    ) u_dut (
        .clk                     (clk),
        .reset                   (reset),
        .board_cal_button        (board_cal_button),
        .board_cal_switchs       (board_cal_switchs),
        .cal_board_digit_ctrl    (cal_board_digit_ctrl),
        .cal_board_digit_seg     (cal_board_digit_seg),
        .cal_board_exe_done      (cal_board_exe_done),
        .cal_board_display_stage (cal_board_display_stage)
    );

    always #50 clk = ~clk;

    task automatic set_row(int idx, string name, int a, logic an, int b, logic bn,
                           logic [2:0] sw, logic signed [rw-1:0] exp, logic inv);
        t_name[idx]  = name;
        t_a[idx]     = a;
        t_a_neg[idx] = an;
        t_b[idx]     = b;
        t_b_neg[idx] = bn;
        t_sw[idx]    = sw;
        t_exp[idx]   = exp;
        t_inv[idx]   = inv;
    endtask

    // reference integer arithmetic, lowest set switch picks the op
    function automatic logic signed [rw-1:0] expected_value(int a, logic an, int b, logic bn,
                                                            logic [2:0] sw);
        int sa;
        int sb;
        int r;
        sa = an ? -a : a;
        sb = bn ? -b : b;
        if (sw[0]) begin
            r = sa + sb;
        end else if (sw[1]) begin
            r = sa - sb;
        end else begin
            r = sa * sb;
        end
        return r;
    endfunction

    function automatic logic [3:0] glyph_of(disp_pkg::seg_t s);
        for (int i = 0; i < 12; i++) begin
            if (disp_pkg::seg_patterns[i] == s) begin
                return i;
            end
        end
        return 4'hf;
    endfunction

    function automatic int page_mag(logic [15:0] g);
        return int'(g[3:0]) + 10 * int'(g[7:4]) + 100 * int'(g[11:8]);
    endfunction

    // sign comes from position 3 of the low page
    function automatic logic signed [rw-1:0] value_of(logic [15:0] low, logic [15:0] high);
        int mag;
        mag = page_mag(low) + 1000 * page_mag(high);
        if (low[15:12] == disp_pkg::glyph_minus) begin
            mag = -mag;
        end
        return mag;
    endfunction

    task automatic check_state_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_stage(string name, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            $display("error %s: expected stage %0d, actual stage %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ctrl(string name, disp_pkg::ctrl_t exp, disp_pkg::ctrl_t act);
        if (act !== exp) begin
            $display("error %s: expected ctrl %b, actual ctrl %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_glyph(string name, logic [3:0] exp, logic [3:0] act);
        if (act !== exp) begin
            $display("error %s: expected glyph %0d, actual glyph %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_page(string name, disp_pkg::page_e exp, logic [1:0] stage);
        if (stage !== {1'b0, exp} + 2'd1) begin
            $display("error %s: expected stage %0d, actual stage %0d", name,
                     {1'b0, exp} + 2'd1, stage);
            errors++;
        end
    endtask

    task automatic check_result(string name, logic signed [rw-1:0] exp,
                                logic signed [rw-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
    endtask

    // one cycle pulse, driven just after the edge
    task automatic press(int idx);
        @(posedge clk);
        #10;
        board_cal_button = '0;
        board_cal_button[idx] = 1'b1;
        @(posedge clk);
        #10;
        board_cal_button = '0;
    endtask

    task automatic set_digit(int d);
        if (d <= 5) begin
            repeat (d) press(cal_pkg::btn_up);
        end else begin
            repeat (10 - d) press(cal_pkg::btn_down);
        end
    endtask

    // cursor starts on digit0 with the live digits cleared
    task automatic enter_operand(int mag, logic neg);
        set_digit(mag % 10);
        press(cal_pkg::btn_left);
        set_digit((mag / 10) % 10);
        press(cal_pkg::btn_left);
        set_digit(mag / 100);
        press(cal_pkg::btn_left);
        if (neg) begin
            press(cal_pkg::btn_up);
        end
        press(cal_pkg::btn_mid);
    endtask

    task automatic capture(string name, output logic [15:0] g);
        logic [3:0] seen;
        seen = '0;
        g = '1;
        for (int i = 0; i < 64 && seen != 4'hf; i++) begin
            @(negedge clk);
            for (int p = 0; p < 4; p++) begin
                if (cal_board_digit_ctrl == ~(disp_pkg::ctrl_t'(1) << p)) begin
                    g[p*4 +: 4] = glyph_of(cal_board_digit_seg);
                    seen[p] = 1'b1;
                end
            end
        end
        if (seen != 4'hf) begin
            $display("%s: display never scanned all four digits", name);
            errors++;
        end
    endtask

    task automatic wait_exe_done(string name, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < 100 && !ok; i++) begin
            @(negedge clk);
            ok = cal_board_exe_done;
        end
        if (!ok) begin
            $display("%s: exe_done never rose after the second operand", name);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int err_start);
        tests++;
        if (errors == err_start) begin
            $display("%-12s ok", name);
        end else begin
            failed_tests++;
            $display("%-12s bad, %0d errors", name, errors - err_start);
        end
    endtask

    task automatic load_table();
        int a;
        int b;
        logic an;
        logic bn;
        logic [2:0] sw;
        set_row(0, "add_pos", 123, 0, 456, 0, 3'b001, 579, 0);
        set_row(1, "sub_neg", 120, 0, 345, 0, 3'b010, -225, 0);
        set_row(2, "mul_max", 999, 0, 999, 0, 3'b100, 998001, 0);
        set_row(3, "mul_neg", 987, 1, 654, 0, 3'b100, -645498, 0);
        set_row(4, "add_negs", 250, 1, 375, 1, 3'b001, -625, 0);
        set_row(5, "prio_add", 800, 0, 50, 1, 3'b111, 750, 0);
        set_row(6, "prio_sub", 15, 0, 40, 1, 3'b110, 55, 0);
        set_row(7, "no_op", 12, 0, 34, 0, 3'b000, 0, 1);
        set_row(8, "sub_zero", 7, 1, 7, 1, 3'b010, 0, 0);
        for (int i = num_fixed; i < num_rows; i++) begin
            a  = $urandom % 1000;
            b  = $urandom % 1000;
            an = $urandom % 2;
            bn = $urandom % 2;
            sw = $urandom % 7 + 1;
            set_row(i, $sformatf("rand_%0d", i), a, an, b, bn, sw,
                    expected_value(a, an, b, bn, sw), 0);
        end
    endtask

    task automatic run_row(int idx);
        logic [15:0]     low;
        logic [15:0]     high;
        disp_pkg::ctrl_t ctrl_seen;
        bit              ok;
        int              err_start;
        err_start = errors;
        @(posedge clk);
        #10;
        board_cal_switchs = t_sw[idx];
        enter_operand(t_a[idx], t_a_neg[idx]);
        enter_operand(t_b[idx], t_b_neg[idx]);
        wait_exe_done(t_name[idx], ok);
        if (ok) begin
            check_page(t_name[idx], disp_pkg::page_low, cal_board_display_stage);
            if (t_inv[idx]) begin
                // invalid result keeps every digit dark
                ctrl_seen = '1;
                repeat (16) begin
                    @(negedge clk);
                    ctrl_seen = ctrl_seen & cal_board_digit_ctrl;
                end
                check_ctrl(t_name[idx], '1, ctrl_seen);
            end else begin
                capture(t_name[idx], low);
                press(cal_pkg::btn_mid);
                @(negedge clk);
                check_page(t_name[idx], disp_pkg::page_high, cal_board_display_stage);
                capture(t_name[idx], high);
                check_result(t_name[idx], t_exp[idx], value_of(low, high));
                // high page repeats the sign on position 3
                check_glyph({t_name[idx], " high sign"},
                            (t_exp[idx] < 0) ? disp_pkg::glyph_minus : disp_pkg::glyph_blank,
                            high[15:12]);
            end
            press(cal_pkg::btn_mid);
            @(negedge clk);
            check_state_flag({t_name[idx], " exe_done"}, 1'b0, cal_board_exe_done);
            check_stage(t_name[idx], 2'd0, cal_board_display_stage);
        end
        wait_cycles(2);
        finish_test(t_name[idx], err_start);
    endtask

    initial begin
        repeat ((num_rows + 2) * 400) @(posedge clk);
        $display("watchdog: run did not finish in the expected number of cycles");
        $display("Test failed");
        $finish;
    end

    initial begin
        int          err_start;
        logic [15:0] g;
        int unsigned rnd;
        clk = 1'b0;
        reset = 1'b1;
        board_cal_button = '0;
        board_cal_switchs = '0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        seed = 48;
        rnd = $urandom(seed);
        load_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        err_start = errors;
        check_state_flag("reset exe_done", 1'b0, cal_board_exe_done);
        check_stage("reset display_stage", 2'd0, cal_board_display_stage);
        check_ctrl("reset digit_ctrl", '1, cal_board_digit_ctrl);
        @(posedge clk);
        #10;
        reset = 1'b0;
        capture("reset", g);
        check_result("reset entry", '0, value_of(g, '0));
        finish_test("reset", err_start);

        // down from 0 and up from 9 both wrap, sign toggles
        err_start = errors;
        press(cal_pkg::btn_down);
        press(cal_pkg::btn_up);
        press(cal_pkg::btn_down);
        press(cal_pkg::btn_left);
        press(cal_pkg::btn_up);
        press(cal_pkg::btn_up);
        press(cal_pkg::btn_left);
        press(cal_pkg::btn_left);
        press(cal_pkg::btn_up);
        capture("entry_wrap", g);
        check_result("entry_wrap", -29, value_of(g, '0));
        press(cal_pkg::btn_up);
        press(cal_pkg::btn_right);
        press(cal_pkg::btn_right);
        press(cal_pkg::btn_down);
        press(cal_pkg::btn_down);
        press(cal_pkg::btn_right);
        press(cal_pkg::btn_up);
        capture("entry_clear", g);
        check_result("entry_clear", 0, value_of(g, '0));
        finish_test("entry_wrap", err_start);

        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/cal_pkg.sv
hdl/disp_pkg.sv
hdl/bcd_result_if.sv
hdl/cal_control.sv
hdl/digit_entry.sv
hdl/int_alu.sv
hdl/bin2bcd.sv
hdl/seg_display.sv
hdl/cal_top.sv
verif/tb_cal_top.sv
